// File: design/rvDecodePkg.sv
package rvDecodePkg;

    localparam int DATA_W = 32;

    // RV32I base opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_SYSTEM = 7'b1110011,
        OP_FENCE  = 7'b0001111
    } opcode_e;

    // Class of operation handed to ALU control
    typedef enum logic [2:0] {
        ALU_LOAD_STORE = 3'b000,
        ALU_BRANCH     = 3'b001,
        ALU_R_TYPE     = 3'b010,
        ALU_I_TYPE     = 3'b011,
        ALU_ADD_UPPER  = 3'b100
    } aluOp_e;

    typedef enum logic [1:0] {
        JUMP_NONE = 2'd0,
        JUMP_JAL  = 2'd1,
        JUMP_JALR = 2'd2
    } jump_e;

    typedef struct packed {
        logic       branch;
        logic       memRead;
        logic       memWrite;
        logic       memToReg;
        aluOp_e     aluOp;
        logic [1:0] aluSrcA;  // 0 rs1, 1 PC, 2 zero
        logic       aluSrcB;  // 1 selects immediate
        logic       regWrite;
        jump_e      jump;
        logic       pcPlus4;
        logic       csrEn;
        logic       ex;       // Trap request
    } ctrl_t;

endpackage

// File: design/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf;
    import rvDecodePkg::*;

    ctrl_t             ctrl;
    logic [DATA_W-1:0] imm;
    logic [DATA_W-1:0] rs1Data;
    logic [DATA_W-1:0] rs2Data;
    logic [4:0]        rd;

    modport ctrlSrc (output ctrl);

    modport immSrc (output imm);

    modport regSrc (output rs1Data, output rs2Data, output rd);

    modport sink (
        input ctrl,
        input imm,
        input rs1Data,
        input rs2Data,
        input rd
    );

endinterface

// File: design/mainControl.sv
`timescale 1ns/1ps

module mainControl (
    input  logic [31:0]    i_instr,
    input  logic           i_flush,
    decodeIf.ctrlSrc       ctrlPort
);
    import rvDecodePkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [11:0] funct12;
    logic [4:0]  rs1;
    logic [4:0]  rd;
    logic        isTrapCall;
    ctrl_t       ctrlNext;

    assign opcode  = i_instr[6:0];
    assign funct3  = i_instr[14:12];
    assign funct12 = i_instr[31:20];
    assign rs1     = i_instr[19:15];
    assign rd      = i_instr[11:7];

    // ECALL or EBREAK
    assign isTrapCall = (funct3 == 3'd0) && (rs1 == 5'd0) && (rd == 5'd0) &&
                        ((funct12 == 12'd0) || (funct12 == 12'd1));

    always_comb begin
        ctrlNext = '0;  // Unused fields stay low
        if (!i_flush) begin
            case (opcode)
                OP_R: begin
                    ctrlNext.regWrite = 1'b1;
                    ctrlNext.aluOp    = ALU_R_TYPE;
                end
                OP_I: begin
                    ctrlNext.aluSrcB  = 1'b1;
                    ctrlNext.regWrite = 1'b1;
                    ctrlNext.aluOp    = ALU_I_TYPE;
                end
                OP_LOAD: begin
                    ctrlNext.memRead  = 1'b1;
                    ctrlNext.memToReg = 1'b1;
                    ctrlNext.aluSrcB  = 1'b1;
                    ctrlNext.regWrite = 1'b1;
                end
                OP_STORE: begin
                    ctrlNext.memWrite = 1'b1;
                    ctrlNext.aluSrcB  = 1'b1;
                end
                OP_BRANCH: begin
                    ctrlNext.branch = 1'b1;
                    ctrlNext.aluOp  = ALU_BRANCH;
                end
                OP_LUI: begin
                    ctrlNext.aluSrcA  = 2'd2;  // Zero plus imm
                    ctrlNext.aluSrcB  = 1'b1;
                    ctrlNext.regWrite = 1'b1;
                    ctrlNext.aluOp    = ALU_ADD_UPPER;
                end
                OP_AUIPC: begin
                    ctrlNext.aluSrcA  = 2'd1;  // PC plus imm
                    ctrlNext.aluSrcB  = 1'b1;
                    ctrlNext.regWrite = 1'b1;
                    ctrlNext.aluOp    = ALU_ADD_UPPER;
                end
                OP_JAL: begin
                    ctrlNext.regWrite = 1'b1;
                    ctrlNext.jump     = JUMP_JAL;
                    ctrlNext.pcPlus4  = 1'b1;
                end
                OP_JALR: begin
                    ctrlNext.aluSrcB  = 1'b1;
                    ctrlNext.regWrite = 1'b1;
                    ctrlNext.aluOp    = ALU_ADD_UPPER;  // rs1 + imm target
                    ctrlNext.jump     = JUMP_JALR;
                    ctrlNext.pcPlus4  = 1'b1;
                end
                OP_FENCE: ;  // NOP
                OP_SYSTEM: begin
                    ctrlNext.regWrite = 1'b1;
                    ctrlNext.csrEn    = 1'b1;
                    ctrlNext.ex       = isTrapCall;
                end
                default: ctrlNext.ex = 1'b1;  // Illegal opcode
            endcase
        end
    end

    assign ctrlPort.ctrl = ctrlNext;

endmodule

// File: design/immGen.sv
`timescale 1ns/1ps

module immGen (
    input  logic [31:0]    i_instr,
    decodeIf.immSrc        immPort
);
    import rvDecodePkg::*;

    logic [DATA_W-1:0] immNext;
    logic              sign;

    assign sign = i_instr[31];

    always_comb begin
        case (i_instr[6:0])
            OP_I, OP_LOAD, OP_JALR:
                immNext = {{20{sign}}, i_instr[31:20]};
            OP_STORE:
                immNext = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
            OP_BRANCH:
                immNext = {{19{sign}}, sign, i_instr[7], i_instr[30:25],
                           i_instr[11:8], 1'b0};
            OP_LUI, OP_AUIPC:
                immNext = {i_instr[31:12], 12'd0};
            OP_JAL:
                immNext = {{11{sign}}, sign, i_instr[19:12], i_instr[20],
                           i_instr[30:21], 1'b0};
            default:
                immNext = '0;  // No immediate field
        endcase
    end

    assign immPort.imm = immNext;

endmodule

// File: design/regFile.sv
`timescale 1ns/1ps

module regFile #(
    parameter int RegCount = 32
) (
    input  logic                          i_Clk,
    input  logic                          i_rstN,
    input  logic [4:0]                    i_rs1Addr,
    input  logic [4:0]                    i_rs2Addr,
    input  logic                          i_wrEn,
    input  logic [4:0]                    i_wrAddr,
    input  logic [rvDecodePkg::DATA_W-1:0] i_wrData,
    decodeIf.regSrc                       regPort
);
    import rvDecodePkg::*;

    localparam int AddrW = $clog2(RegCount);

    logic [DATA_W-1:0] regs [RegCount];
    logic [AddrW-1:0]  wrIdx;
    logic [AddrW-1:0]  rs1Idx;
    logic [AddrW-1:0]  rs2Idx;

    assign wrIdx  = i_wrAddr[AddrW-1:0];   // Upper bits ignored for RV32E
    assign rs1Idx = i_rs1Addr[AddrW-1:0];
    assign rs2Idx = i_rs2Addr[AddrW-1:0];

    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            regs <= '{default: '0};
        end else if (i_wrEn && (wrIdx != '0)) begin
            regs[wrIdx] <= i_wrData;
        end
    end

    function automatic logic [DATA_W-1:0] readReg(input logic [AddrW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (i_wrEn && (addr == wrIdx)) begin
            return i_wrData;  // Write bypass
        end
        return regs[addr];
    endfunction

    always_comb begin
        regPort.rs1Data = readReg(rs1Idx);
        regPort.rs2Data = readReg(rs2Idx);
    end

endmodule

// File: design/decodeHandshake.sv
`timescale 1ns/1ps

module decodeHandshake (
    input  logic                           i_Clk,
    input  logic                           i_rstN,
    input  logic                           i_req,
    output logic                           o_ack,
    decodeIf.sink                          bundle,
    output rvDecodePkg::ctrl_t             o_ctrl,
    output logic [rvDecodePkg::DATA_W-1:0] o_imm,
    output logic [rvDecodePkg::DATA_W-1:0] o_rs1Data,
    output logic [rvDecodePkg::DATA_W-1:0] o_rs2Data,
    output logic [4:0]                     o_rd
);

    logic capture;
    logic release_;

    // Ack follows req one edge later
    assign capture  = i_req && !o_ack;
    assign release_ = !i_req && o_ack;

    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_ack <= 1'b0;
        end else if (capture) begin
            o_ack <= 1'b1;
        end else if (release_) begin
            o_ack <= 1'b0;
        end
    end

    // Results held until the next request is taken
    always_ff @(posedge i_Clk or negedge i_rstN) begin
        if (!i_rstN) begin
            o_ctrl    <= '0;
            o_imm     <= '0;
            o_rs1Data <= '0;
            o_rs2Data <= '0;
            o_rd      <= '0;
        end else if (capture) begin
            o_ctrl    <= bundle.ctrl;
            o_imm     <= bundle.imm;
            o_rs1Data <= bundle.rs1Data;
            o_rs2Data <= bundle.rs2Data;
            o_rd      <= bundle.rd;
        end
    end

endmodule

// File: design/decodeTop.sv
`timescale 1ns/1ps

module decodeTop #(
    parameter int RegCount = 32
) (
    input  logic                           i_Clk,
    input  logic                           i_rstN,
    input  logic                           i_req,
    input  logic [31:0]                    i_instr,
    input  logic                           i_flush,
    output logic                           o_ack,
    input  logic                           i_wrEn,
    input  logic [4:0]                     i_wrAddr,
    input  logic [rvDecodePkg::DATA_W-1:0] i_wrData,
    output logic                           o_branch,
    output logic                           o_memRead,
    output logic                           o_memWrite,
    output logic                           o_memToReg,
    output logic [2:0]                     o_aluOp,
    output logic [1:0]                     o_aluSrcA,
    output logic                           o_aluSrcB,
    output logic                           o_regWrite,
    output logic [1:0]                     o_jump,
    output logic                           o_pcPlus4,
    output logic                           o_csrEn,
    output logic                           o_ex,
    output logic [rvDecodePkg::DATA_W-1:0] o_imm,
    output logic [rvDecodePkg::DATA_W-1:0] o_rs1Data,
    output logic [rvDecodePkg::DATA_W-1:0] o_rs2Data,
    output logic [4:0]                     o_rd
);
    import rvDecodePkg::*;

    ctrl_t ctrlQ;

    decodeIf bus ();

    assign bus.rd = i_instr[11:7];

    mainControl uCtrl (
        .i_instr  (i_instr),
        .i_flush  (i_flush),
        .ctrlPort (bus.ctrlSrc)
    );

    immGen uImm (
        .i_instr (i_instr),
        .immPort (bus.immSrc)
    );

    regFile #(.RegCount(RegCount)) uRegs (
        .i_Clk     (i_Clk),
        .i_rstN    (i_rstN),
        .i_rs1Addr (i_instr[19:15]),
        .i_rs2Addr (i_instr[24:20]),
        .i_wrEn    (i_wrEn),
        .i_wrAddr  (i_wrAddr),
        .i_wrData  (i_wrData),
        .regPort   (bus.regSrc)
    );

    decodeHandshake uHs (
        .i_Clk     (i_Clk),
        .i_rstN    (i_rstN),
        .i_req     (i_req),
        .o_ack     (o_ack),
        .bundle    (bus.sink),
        .o_ctrl    (ctrlQ),
        .o_imm     (o_imm),
        .o_rs1Data (o_rs1Data),
        .o_rs2Data (o_rs2Data),
        .o_rd      (o_rd)
    );

    // Registered bundle out to plain ports
    assign o_branch   = ctrlQ.branch;
    assign o_memRead  = ctrlQ.memRead;
    assign o_memWrite = ctrlQ.memWrite;
    assign o_memToReg = ctrlQ.memToReg;
    assign o_aluOp    = ctrlQ.aluOp;
    assign o_aluSrcA  = ctrlQ.aluSrcA;
    assign o_aluSrcB  = ctrlQ.aluSrcB;
    assign o_regWrite = ctrlQ.regWrite;
    assign o_jump     = ctrlQ.jump;
    assign o_pcPlus4  = ctrlQ.pcPlus4;
    assign o_csrEn    = ctrlQ.csrEn;
    assign o_ex       = ctrlQ.ex;

endmodule

// File: sim/decodeTop_props.sv
`timescale 1ns/1ps

module decodeTop_props (
    input logic                           i_Clk,
    input logic                           i_rstN,
    input logic                           i_req,
    input logic                           o_ack,
    input rvDecodePkg::ctrl_t             ctrlQ,
    input logic [rvDecodePkg::DATA_W-1:0] o_imm,
    input logic [rvDecodePkg::DATA_W-1:0] o_rs1Data,
    input logic [rvDecodePkg::DATA_W-1:0] o_rs2Data,
    input logic [4:0]                     o_rd
);

    int failCount = 0;

    ackRiseOnReq: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        $rose(o_ack) |-> $past(i_req))
        else begin
            $error("o_ack rose while i_req was low");
            failCount++;
        end

    ackFallAfterReq: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        $fell(o_ack) |-> !$past(i_req))
        else begin
            $error("o_ack fell while i_req was high");
            failCount++;
        end

    // No capture can happen while ack is up
    outputsHeld: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        $past(o_ack) |-> $stable({ctrlQ, o_imm, o_rs1Data, o_rs2Data, o_rd}))
        else begin
            $error("Outputs changed while o_ack was high");
            failCount++;
        end

endmodule

bind decodeTop decodeTop_props props (.*);

// File: sim/decodeTb.sv
`timescale 1ns/1ps

module decodeTb;
    import rvDecodePkg::*;

    localparam int PeriodNs   = 100;
    localparam int AckBound   = 8;   // Cycles allowed per handshake phase
    localparam int SendCount  = 60;  // Upper bound on handshakes over all tests
    localparam int WatchdogNs = (10 + SendCount * 2 * AckBound) * PeriodNs * 2;

    localparam logic [6:0] OpList [12] = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011,
        7'b1100011, 7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1110011,
        7'b0001111, 7'b1111111};  // Last one is undefined

    logic        i_Clk = 1'b0;
    logic        i_rstN, i_req, i_flush, i_wrEn;
    logic [31:0] i_instr, i_wrData;
    logic [4:0]  i_wrAddr;
    logic        o_ack, o_branch, o_memRead, o_memWrite, o_memToReg, o_aluSrcB;
    logic        o_regWrite, o_pcPlus4, o_csrEn, o_ex;
    logic [2:0]  o_aluOp;
    logic [1:0]  o_aluSrcA, o_jump;
    logic [31:0] o_imm, o_rs1Data, o_rs2Data;
    logic [4:0]  o_rd;
    logic [31:0] shadow [32];  // Expected register contents
    int          seed;

    decodeTop #(.RegCount(32)) dut (.*);

    always #(PeriodNs / 2) i_Clk = ~i_Clk;

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic checkVal(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        assert (actVal === expVal) else
            abortRun($sformatf("Fail at %0t ns: %s expected %h, actual %h",
                               $time, name, expVal, actVal));
    endtask

    // Same field order as the control ports, branch in the MSB
    function automatic logic [15:0] refCtrl(input logic [31:0] instr, input logic flush);
        logic trap;
        trap = (instr[14:12] == 3'd0) && (instr[19:15] == 5'd0) && (instr[11:7] == 5'd0) &&
               (instr[31:21] == 11'd0);  // ECALL or EBREAK
        if (flush) return 16'd0;
        case (instr[6:0])
            7'b0110011: return 16'b0_0_0_0_010_00_0_1_00_0_0_0;
            7'b0010011: return 16'b0_0_0_0_011_00_1_1_00_0_0_0;
            7'b0000011: return 16'b0_1_0_1_000_00_1_1_00_0_0_0;
            7'b0100011: return 16'b0_0_1_0_000_00_1_0_00_0_0_0;
            7'b1100011: return 16'b1_0_0_0_001_00_0_0_00_0_0_0;
            7'b0110111: return 16'b0_0_0_0_100_10_1_1_00_0_0_0;
            7'b0010111: return 16'b0_0_0_0_100_01_1_1_00_0_0_0;
            7'b1101111: return 16'b0_0_0_0_000_00_0_1_01_1_0_0;
            7'b1100111: return 16'b0_0_0_0_100_00_1_1_10_1_0_0;
            7'b1110011: return 16'b0_0_0_0_000_00_0_1_00_0_1_0 | {15'd0, trap};
            7'b0001111: return 16'd0;
            default:    return 16'd1;  // ex alone
        endcase
    endfunction

    function automatic logic [31:0] refImm(input logic [31:0] instr);
        logic signed [31:0] s;
        case (instr[6:0])
            7'b0010011, 7'b0000011, 7'b1100111: s = $signed(instr[31:20]);
            7'b0100011: s = $signed({instr[31:25], instr[11:7]});
            7'b1100011: s = $signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0});
            7'b0110111, 7'b0010111: s = {instr[31:12], 12'h000};
            7'b1101111: s = $signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0});
            default: s = 0;
        endcase
        return s;
    endfunction

    task automatic checkCtrl(input logic [15:0] e);
        checkVal("o_branch", e[15], o_branch);
        checkVal("o_memRead", e[14], o_memRead);
        checkVal("o_memWrite", e[13], o_memWrite);
        checkVal("o_memToReg", e[12], o_memToReg);
        checkVal("o_aluOp", e[11:9], o_aluOp);
        checkVal("o_aluSrcA", e[8:7], o_aluSrcA);
        checkVal("o_aluSrcB", e[6], o_aluSrcB);
        checkVal("o_regWrite", e[5], o_regWrite);
        checkVal("o_jump", e[4:3], o_jump);
        checkVal("o_pcPlus4", e[2], o_pcPlus4);
        checkVal("o_csrEn", e[1], o_csrEn);
        checkVal("o_ex", e[0], o_ex);
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic sendInstr(input logic [31:0] instr, input logic flush);
        int waitCycles;
        i_instr = instr;
        i_flush = flush;
        i_req   = 1'b1;
        waitCycles = 0;
        while (!o_ack && waitCycles < AckBound) begin
            @(posedge i_Clk);
            #1;
            waitCycles++;
        end
        assert (o_ack) else abortRun("o_ack did not rise after i_req was raised");
        i_req = 1'b0;
        waitCycles = 0;
        while (o_ack && waitCycles < AckBound) begin
            @(posedge i_Clk);
            #1;
            waitCycles++;
        end
        assert (!o_ack) else abortRun("o_ack did not fall after i_req was dropped");
    endtask

    task automatic decodeAndCheck(input logic [31:0] instr, input logic flush);
        sendInstr(instr, flush);
        checkCtrl(refCtrl(instr, flush));
        checkVal("o_imm", refImm(instr), o_imm);
        checkVal("o_rs1Data", shadow[instr[19:15]], o_rs1Data);
        checkVal("o_rs2Data", shadow[instr[24:20]], o_rs2Data);
        checkVal("o_rd", instr[11:7], o_rd);
    endtask

    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        i_wrEn   = 1'b1;
        i_wrAddr = addr;
        i_wrData = data;
        @(posedge i_Clk);
        #1;
        i_wrEn = 1'b0;
        if (addr != 5'd0) shadow[addr] = data;
    endtask

    task automatic testReset();
        checkVal("o_ack", 0, o_ack);
        checkCtrl(16'd0);
        checkVal("o_imm", 0, o_imm);
        checkVal("o_rs1Data", 0, o_rs1Data);
        checkVal("o_rs2Data", 0, o_rs2Data);
        checkVal("o_rd", 0, o_rd);
    endtask

    // Random upper bits also exercise every immediate format
    task automatic testOpcodes();
        logic [31:0] r;
        repeat (4) begin
            for (int k = 0; k < 12; k++) begin
                r = $random(seed);
                decodeAndCheck({r[31:7], OpList[k]}, 1'b0);
            end
        end
    endtask

    task automatic testSystem();
        logic [31:0] instrs [4];
        logic        expEx [4];
        instrs = '{32'h0000_0073, 32'h0010_0073, 32'h3000_22f3, 32'h0000_002b};
        expEx  = '{1'b1, 1'b1, 1'b0, 1'b1};  // ECALL, EBREAK, csrrs, bad opcode
        for (int k = 0; k < 4; k++) begin
            decodeAndCheck(instrs[k], 1'b0);
            checkVal("o_ex", expEx[k], o_ex);
            checkVal("o_csrEn", k < 3, o_csrEn);
            checkVal("o_regWrite", k < 3, o_regWrite);
        end
    endtask

    task automatic testRegs();
        logic [31:0] v;
        for (int r = 1; r < 8; r++) begin
            v = $random(seed);
            writeReg(r[4:0], v);
        end
        writeReg(5'd0, 32'hdead_beef);  // Must be dropped
        decodeAndCheck({7'd0, 5'd5, 5'd3, 3'd0, 5'd9, 7'b0110011}, 1'b0);
        decodeAndCheck({7'd0, 5'd7, 5'd0, 3'd0, 5'd10, 7'b0110011}, 1'b0);
        v = $random(seed);
        i_wrEn    = 1'b1;  // New x4 lands on the capture edge
        i_wrAddr  = 5'd4;
        i_wrData  = v;
        shadow[4] = v;
        decodeAndCheck({7'd0, 5'd1, 5'd4, 3'd0, 5'd11, 7'b0110011}, 1'b0);
        i_wrEn = 1'b0;
    endtask

    task automatic testFlush();
        decodeAndCheck(32'h0000_0073, 1'b1);
        checkVal("o_ex", 0, o_ex);
    endtask

    always @(dut.props.failCount) begin
        if (dut.props.failCount != 0) abortRun("A bound handshake or hold assertion failed");
    end

    initial begin
        seed     = 32'hb8ab_9c26;
        i_rstN   = 1'b0;
        i_req    = 1'b0;
        i_flush  = 1'b0;
        i_instr  = '0;
        i_wrEn   = 1'b0;
        i_wrAddr = '0;
        i_wrData = '0;
        foreach (shadow[k]) shadow[k] = '0;
        repeat (10) @(posedge i_Clk);
        #1;
        i_rstN = 1'b1;
        testReset();
        testOpcodes();
        testSystem();
        testRegs();
        testFlush();
        $display("NO ERRORS");
        $finish;
    end

    initial begin
        #(WatchdogNs);
        abortRun("Timeout: the tests did not finish in the expected time");
    end

endmodule

// File: project.f
design/rvDecodePkg.sv
design/decodeIf.sv
design/mainControl.sv
design/immGen.sv
design/regFile.sv
design/decodeHandshake.sv
design/decodeTop.sv
sim/decodeTop_props.sv
sim/decodeTb.sv

// File: Bender.yml
package:
  name: rv_decode

sources:
  - design/rvDecodePkg.sv
  - design/decodeIf.sv
  - design/mainControl.sv
  - design/immGen.sv
  - design/regFile.sv
  - design/decodeHandshake.sv
  - design/decodeTop.sv
  - target: simulation
    files:
      - sim/decodeTop_props.sv
      - sim/decodeTb.sv
